// ==== sim.f ====
+incdir+hdl
hdl/cpuPkg.sv
hdl/busPkg.sv
hdl/alu.sv
hdl/sequencer.sv
hdl/console.sv
hdl/pi.sv
hdl/busIntf.sv
hdl/cpu.sv
verif/tb.sv

// ==== Makefile ====
# Verilator build and run for the processor testbench

VERILATOR ?= verilator
TOP       ?= tb
FILELIST  ?= sim.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= >>> PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR) -o V$(TOP)

# Pass only if the log holds the pass line
run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q -F '$(PASS_MSG)' $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== verif/tb.sv ====
/*
 * Processor testbench
 * Memory responder, instruction-level reference model and directed runs
 */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module tb;

   localparam int MEM_WORDS = 1024;      // Addresses above never answer
   localparam int NUM_TESTS = 5;

   typedef enum {phFetch, phOperand, phStore} modelPhase;

   logic            clk, reset;
   logic            cslRun, cslHalt, brkptHalt;
   logic            cpuRun, cpuHalt, cslIntr;
   logic [7:1]      ubaIntr;
   logic            cpuReq, cpuAck;
   busPkg::busAddr  cpuAddr;
   cpuPkg::word     cpuData, cpuDataIn;

   cpuPkg::word     mem [0:MEM_WORDS-1];
   logic [31:0]     rngState = 32'ha2b9e8ee;

   // Reference model
   modelPhase       mPhase;               // Next expected cycle
   cpuPkg::addr     mPc;
   cpuPkg::word     mAcc;
   cpuPkg::piLevel  mCur;                 // Level in service
   cpuPkg::opCode   mOp;
   cpuPkg::addr     mOpAddr;
   int              instrCount, vecCount, storeCount;
   int              errCount, checkCount, errMark, testCount;
   logic            quiet;                // Halted, bus must stay idle
   logic            reqActive;
   int              ackDelay;
   cpuPkg::word     lastWrData;
   int              vecBefore;
   busPkg::busAddr  firstFetch;

   cpu dut_i (
      .clk (clk), .reset (reset), .cslRun (cslRun), .cslHalt (cslHalt),
      .brkptHalt (brkptHalt), .cpuRun (cpuRun), .cpuHalt (cpuHalt), .cslIntr (cslIntr),
      .ubaIntr (ubaIntr), .cpuReq (cpuReq), .cpuAddr (cpuAddr), .cpuData (cpuData),
      .cpuAck (cpuAck), .cpuDataIn (cpuDataIn)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;             // 100 ns period
   end

   //////////////////////////////
   // Helpers
   //////////////////////////////

   function automatic logic [31:0] nextRand();
      rngState = rngState * 32'd1664525 + 32'd1013904223;   // LCG step
      return rngState;
   endfunction

   function automatic cpuPkg::word makeInstr(logic [3:0] op, cpuPkg::addr ea);
      return {op, 14'(nextRand()), ea};   // Middle bits are junk
   endfunction

   // Arithmetic, logic, load, store or no-op, stores land above 512
   function automatic cpuPkg::word randomInstr();
      int sel;
      sel = int'(nextRand() % 32'd12);
      if (sel < 6) return makeInstr(4'(sel + 1), 18'(nextRand() % 32'd1024));
      if (sel < 8) return makeInstr(4'h7, 18'(32'd512 + nextRand() % 32'd512));
      return makeInstr(4'(sel + 4), 18'(nextRand() % 32'd1024));   // Codes C..F
   endfunction

   function automatic cpuPkg::piLevel highestLevel(logic [7:1] req);
      cpuPkg::piLevel lvl;
      lvl = '0;
      for (int n = 1; n <= 7; n++) begin
         if (req[n] && lvl == '0) lvl = 3'(n);   // First set bit, level 1 on top
      end
      return lvl;
   endfunction

   function automatic cpuPkg::word applyOp(cpuPkg::opCode op, cpuPkg::word a, cpuPkg::word b);
      case (op)
         cpuPkg::opAdd:  return a + b;    // Wraps at 36 bits
         cpuPkg::opSub:  return a - b;
         cpuPkg::opAnd:  return a & b;
         cpuPkg::opOr:   return a | b;
         cpuPkg::opXor:  return a ^ b;
         cpuPkg::opLoad: return b;
         default:        return a;
      endcase
   endfunction

   task automatic checkWord(string name, cpuPkg::word got, cpuPkg::word exp);
      checkCount++;
      if (got !== exp) begin
         errCount++;
         $display("Fail %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic checkAddr(string name, busPkg::busAddr got, busPkg::busAddr exp);
      checkCount++;
      if (got !== exp) begin
         errCount++;
         $display("Fail %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic checkBit(string name, logic got, logic exp);
      checkCount++;
      if (got !== exp) begin
         errCount++;
         $display("Fail %s: got %h, expected %h", name, got, exp);
      end
   endtask

   //////////////////////////////
   // Model step per request
   //////////////////////////////

   task automatic modelRequest();
      busPkg::busAddr expAddr;
      cpuPkg::word    expData;
      cpuPkg::word    instr;
      cpuPkg::piLevel lvl;
      logic           isWrite;
      expAddr = '0;
      expData = '0;
      isWrite = 1'b0;
      lvl     = highestLevel(ubaIntr);
      case (mPhase)
         phFetch: begin
            if (lvl != '0 && (mCur == '0 || lvl < mCur)) begin
               expAddr.write   = 1'b1;                       // Vector cycle
               expAddr.address = `INTR_BASE + 18'(lvl);
               expData         = mAcc;                       // Write data register
               isWrite         = 1'b1;
               mCur            = lvl;
               vecCount++;
            end else begin
               expAddr.read    = 1'b1;
               expAddr.address = mPc;
               instr           = mem[mPc[9:0]];
               mOp             = cpuPkg::opCode'(instr[35:32]);
               mOpAddr         = instr[17:0];
               mPc             = mPc + 1'b1;
               instrCount++;
               case (mOp)
                  cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opAnd,
                  cpuPkg::opOr, cpuPkg::opXor, cpuPkg::opLoad: mPhase = phOperand;
                  cpuPkg::opStore:   mPhase = phStore;
                  cpuPkg::opDismiss: mCur = '0;              // Back to none
                  default: ;                                 // Halt and no-ops
               endcase
            end
         end
         phOperand: begin
            expAddr.read    = 1'b1;
            expAddr.address = mOpAddr;
            // Missing memory reads as zero
            mAcc   = applyOp(mOp, mAcc, (mOpAddr < 18'(MEM_WORDS)) ? mem[mOpAddr[9:0]] : '0);
            mPhase = phFetch;
         end
         phStore: begin
            expAddr.write   = 1'b1;
            expAddr.address = mOpAddr;
            expData         = mAcc;
            isWrite         = 1'b1;
            storeCount++;
            mPhase          = phFetch;
         end
      endcase
      checkAddr("cpuAddr", cpuAddr, expAddr);
      if (isWrite) checkWord("cpuData", cpuData, expData);
   endtask

   //////////////////////////////
   // Memory responder
   //////////////////////////////

   initial begin
      cpuAck    = 1'b0;
      cpuDataIn = '0;
      reqActive = 1'b0;
      ackDelay  = 0;
      forever begin
         @(posedge clk);
         #1;
         cpuAck = 1'b0;                   // One cycle pulse
         if (!cpuReq) reqActive = 1'b0;
         if (cpuReq && !reqActive) begin
            reqActive = 1'b1;
            if (quiet) begin
               errCount++;
               $display("Request to %h started while the CPU was halted", cpuAddr.address);
            end
            modelRequest();
            ackDelay = int'(nextRand() % 32'd4);             // 0 to 3 cycles
         end
         if (reqActive && cpuAddr.address < 18'(MEM_WORDS)) begin
            if (ackDelay == 0) begin
               cpuAck = 1'b1;
               if (cpuAddr.read) cpuDataIn = mem[cpuAddr.address[9:0]];
               if (cpuAddr.write) begin
                  mem[cpuAddr.address[9:0]] = cpuData;
                  lastWrData = cpuData;
               end
            end else begin
               ackDelay--;
            end
         end
      end
   end

   //////////////////////////////
   // Test sequence
   //////////////////////////////

   task automatic nextCycle();
      @(posedge clk);
      #1;
   endtask

   task automatic resume();
      cslRun = 1'b1;
      quiet  = 1'b0;
      nextCycle();
      cslRun = 1'b0;
   endtask

   task automatic waitHalt();
      while (cpuHalt !== 1'b1) nextCycle();   // Watchdog bounds this
      quiet = 1'b1;
   endtask

   // Bus stays idle once halted
   task automatic checkIdle();
      repeat (20) nextCycle();
      checkBit("cpuHalt", cpuHalt, 1'b1);
      checkBit("cpuRun", cpuRun, 1'b0);
      checkBit("cpuReq", cpuReq, 1'b0);
   endtask

   // Instruction at an offset from the next model fetch
   task automatic plantInstr(int offset, logic [3:0] op, cpuPkg::addr ea);
      mem[10'(int'(mPc) + offset)] = makeInstr(op, ea);
   endtask

   task automatic finishTest(string name);
      testCount++;
      $display("Test %0d %s: %0d errors", testCount, name, errCount - errMark);
      errMark = errCount;
   endtask

   initial begin
      reset     = 1'b1;
      cslRun    = 1'b0;
      cslHalt   = 1'b0;
      brkptHalt = 1'b0;
      ubaIntr   = '0;
      quiet     = 1'b1;
      {instrCount, vecCount, storeCount} = '0;
      {errCount, checkCount, errMark, testCount} = '0;
      lastWrData = '0;
      mPhase  = phFetch;
      mPc     = `START_ADDR;
      mAcc    = '0;
      mCur    = '0;
      mOp     = cpuPkg::opAdd;
      mOpAddr = '0;
      for (int i = 0; i < MEM_WORDS; i++) mem[i] = randomInstr();
      mem[200] = makeInstr(cpuPkg::opHalt, '0);             // Ends the random program
      repeat (5) @(posedge clk);
      #1;
      reset = 1'b0;

      // Reset state and first fetch
      checkBit("cpuRun", cpuRun, 1'b0);
      checkBit("cpuHalt", cpuHalt, 1'b1);
      checkBit("cpuReq", cpuReq, 1'b0);
      checkBit("cslIntr", cslIntr, 1'b0);
      firstFetch.read    = 1'b1;
      firstFetch.write   = 1'b0;
      firstFetch.address = `START_ADDR;
      resume();
      while (cpuReq !== 1'b1) nextCycle();
      checkAddr("cpuAddr", cpuAddr, firstFetch);
      finishTest("reset and first fetch");

      // Random program up to the halt at 200
      waitHalt();
      checkWord("instructions", cpuPkg::word'(instrCount), cpuPkg::word'(201));
      checkBit("stores", storeCount > 0, 1'b1);
      finishTest("random program");

      // Halt instruction, console halt, breakpoint
      checkIdle();
      resume();
      repeat (5 + int'(nextRand() % 32'd36)) nextCycle();
      cslHalt = 1'b1;
      nextCycle();
      cslHalt = 1'b0;
      waitHalt();
      checkIdle();
      resume();
      repeat (5 + int'(nextRand() % 32'd36)) nextCycle();
      brkptHalt = 1'b1;
      waitHalt();
      brkptHalt = 1'b0;
      checkIdle();
      finishTest("halt sources");

      // Interrupt taken, held off, taken again after dismiss
      ubaIntr = 7'(nextRand() % 32'd127 + 32'd1);
      plantInstr(6, cpuPkg::opDismiss, '0);
      plantInstr(12, cpuPkg::opHalt, '0);
      vecBefore = vecCount;
      resume();
      waitHalt();
      checkIdle();
      ubaIntr = '0;
      checkWord("vectors", cpuPkg::word'(vecCount - vecBefore), cpuPkg::word'(2));
      finishTest("interrupts");

      // Operand read from missing memory
      plantInstr(0, cpuPkg::opLoad, 18'h3ffff);
      plantInstr(1, cpuPkg::opStore, 18'd600);
      plantInstr(2, cpuPkg::opHalt, '0);
      plantInstr(3, cpuPkg::opHalt, '0);
      resume();
      waitHalt();
      checkIdle();
      checkWord("store data", lastWrData, '0);
      checkBit("cslIntr", cslIntr, 1'b1);                   // Still set while halted
      resume();
      checkBit("cslIntr", cslIntr, 1'b0);
      waitHalt();
      checkIdle();
      finishTest("non-existent memory");

      $display("Tests %0d, checks %0d, errors %0d", testCount, checkCount, errCount);
      if (errCount == 0) $display(">>> PASS");
      else $display(">>> FAIL");
      $finish;
   end

   // Generous bound per test
   initial begin
      #(NUM_TESTS * 200 * 30 * 100);
      $display("Timeout: the run did not reach its end");
      $display(">>> FAIL");
      $finish;
   end

endmodule

// ==== hdl/cpu.sv ====
/*
 * Processor top level
 * Connects sequencer, ALU, bus interface, interrupts and console
 */
`timescale 1ns/1ps

module cpu (
   input  logic            clk,
   input  logic            reset,
   // Console
   input  logic            cslRun,       // Run strobe
   input  logic            cslHalt,      // Halt strobe
   input  logic            brkptHalt,    // Breakpoint
   output logic            cpuRun,
   output logic            cpuHalt,
   output logic            cslIntr,      // NXM to console
   // Unibus interrupts
   input  logic [7:1]      ubaIntr,
   // Memory bus
   output logic            cpuReq,
   output busPkg::busAddr  cpuAddr,
   output cpuPkg::word     cpuData,
   input  logic            cpuAck,
   input  cpuPkg::word     cpuDataIn
);

   logic            busStart;
   busPkg::busAddr  busReq;
   logic            busDone;
   cpuPkg::word     rdData;
   cpuPkg::word     acc;
   logic            aluLoad;
   cpuPkg::opCode   aluOp;
   logic            atBoundary, haltInstr;
   logic            piIntr, piTake, piDismiss;
   cpuPkg::piLevel  piReqLevel;

   //////////////////////////////
   // Datapath and control
   //////////////////////////////

   sequencer uSequencer (
      .clk (clk), .reset (reset), .cpuRun (cpuRun), .piIntr (piIntr),
      .piReqLevel (piReqLevel), .busDone (busDone), .rdData (rdData),
      .busStart (busStart), .busReq (busReq), .aluLoad (aluLoad), .aluOp (aluOp),
      .atBoundary (atBoundary), .haltInstr (haltInstr), .piTake (piTake),
      .piDismiss (piDismiss)
   );

   alu uAlu (
      .clk (clk), .reset (reset), .aluLoad (aluLoad), .aluOp (aluOp),
      .operand (rdData), .acc (acc)
   );

   // Memory bus, with NXM check
   busIntf uBusIntf (
      .clk (clk), .reset (reset), .busStart (busStart), .busReq (busReq),
      .acc (acc), .cslRun (cslRun), .cpuAck (cpuAck), .cpuDataIn (cpuDataIn),
      .cpuReq (cpuReq), .cpuAddr (cpuAddr), .cpuData (cpuData),
      .busDone (busDone), .rdData (rdData), .nxmFlag (cslIntr)
   );

   //////////////////////////////
   // Interrupts and console
   //////////////////////////////

   pi uPi (
      .clk (clk), .reset (reset), .ubaIntr (ubaIntr), .piTake (piTake),
      .piDismiss (piDismiss), .piIntr (piIntr), .piReqLevel (piReqLevel)
   );

   console uConsole (
      .clk (clk), .reset (reset), .cslRun (cslRun), .cslHalt (cslHalt),
      .brkptHalt (brkptHalt), .atBoundary (atBoundary), .haltInstr (haltInstr),
      .cpuRun (cpuRun), .cpuHalt (cpuHalt)
   );

endmodule

// ==== hdl/busIntf.sv ====
/*
 * Bus interface
 * Registers each request, holds cpuReq until acknowledge,
 * and ends the cycle on a non-existent memory timeout
 */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module busIntf (
   input  logic            clk,
   input  logic            reset,
   input  logic            busStart,     // From sequencer
   input  busPkg::busAddr  busReq,
   input  cpuPkg::word     acc,          // Write data
   input  logic            cslRun,       // Clears NXM
   input  logic            cpuAck,
   input  cpuPkg::word     cpuDataIn,
   output logic            cpuReq,
   output busPkg::busAddr  cpuAddr,
   output cpuPkg::word     cpuData,
   output logic            busDone,      // Cycle over
   output cpuPkg::word     rdData,
   output logic            nxmFlag       // Sticky
);

   logic [`NXM_BITS-1:0] waitCount;      // Cycles with cpuReq high
   logic                 timeout;

   assign timeout = (waitCount == `NXM_BITS'(`NXM_TIMEOUT - 1));

   //////////////////////////////
   // Request and handshake
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         cpuReq    <= 1'b0;
         busDone   <= 1'b0;
         nxmFlag   <= 1'b0;
         waitCount <= '0;
      end else begin
         busDone <= 1'b0;
         if (cslRun) nxmFlag <= 1'b0;
         if (busStart) begin
            cpuReq    <= 1'b1;
            waitCount <= '0;
         end else if (cpuReq) begin
            if (cpuAck || timeout) begin
               cpuReq  <= 1'b0;
               busDone <= 1'b1;
               if (!cpuAck) nxmFlag <= 1'b1;   // Nobody answered
            end else begin
               waitCount <= waitCount + 1'b1;
            end
         end
      end
   end

   // Address, data and read data
   always_ff @(posedge clk) begin
      if (busStart) begin
         cpuAddr <= busReq;
         cpuData <= acc;
      end
      if (cpuReq && cpuAck) begin
         rdData <= cpuDataIn;
      end else if (cpuReq && timeout) begin
         rdData <= '0;                   // NXM reads as zero
      end
   end

endmodule

// ==== hdl/pi.sv ====
/*
 * Priority interrupt controller
 * Picks the highest pending Unibus level and tracks the one in service
 */
`timescale 1ns/1ps

module pi (
   input  logic            clk,
   input  logic            reset,
   input  logic [7:1]      ubaIntr,      // Bit n is level n
   input  logic            piTake,       // Vector written
   input  logic            piDismiss,    // Service done
   output logic            piIntr,
   output cpuPkg::piLevel  piReqLevel    // Highest pending
);

   cpuPkg::piLevel curLevel;             // In service, 0 for none

   //////////////////////////////
   // Request priority
   //////////////////////////////

   // Scan from lowest priority up, last hit wins
   always_comb begin
      piReqLevel = '0;
      for (int lvl = 7; lvl >= 1; lvl--) begin
         if (ubaIntr[lvl]) begin
            piReqLevel = cpuPkg::piLevel'(lvl);
         end
      end
   end

   // Smaller number outranks
   assign piIntr = (piReqLevel != '0) &&
                   ((curLevel == '0) || (piReqLevel < curLevel));

   //////////////////////////////
   // Level in service
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         curLevel <= '0;
      end else if (piTake) begin
         curLevel <= piReqLevel;
      end else if (piDismiss) begin
         curLevel <= '0;                 // No nesting, back to none
      end
   end

endmodule

// ==== hdl/console.sv ====
/*
 * Console run/halt control
 * Halt requests wait for an instruction boundary
 */
`timescale 1ns/1ps

module console (
   input  logic clk,
   input  logic reset,
   input  logic cslRun,       // Run strobe
   input  logic cslHalt,      // Halt strobe
   input  logic brkptHalt,    // Breakpoint hit
   input  logic atBoundary,   // From sequencer
   input  logic haltInstr,    // Halt instruction executed
   output logic cpuRun,
   output logic cpuHalt
);

   logic haltPend;            // Halt waiting for boundary

   //////////////////////////////
   // Run state
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         cpuRun   <= 1'b0;
         cpuHalt  <= 1'b1;    // Comes up halted
         haltPend <= 1'b0;
      end else begin
         if (cslHalt || brkptHalt || haltInstr) begin
            haltPend <= 1'b1;
         end
         // Stop between instructions only
         if (atBoundary && haltPend) begin
            cpuRun  <= 1'b0;
            cpuHalt <= 1'b1;
         end
         // Resume, drops any stale halt
         if (cslRun && cpuHalt) begin
            cpuRun   <= 1'b1;
            cpuHalt  <= 1'b0;
            haltPend <= 1'b0;
         end
      end
   end

endmodule

// ==== hdl/sequencer.sv ====
/*
 * Instruction sequencer
 * Holds PC and IR, fetches and executes one instruction at a time,
 * and starts a vector write on an interrupt
 */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module sequencer (
   input  logic            clk,
   input  logic            reset,
   input  logic            cpuRun,       // Console run state
   input  logic            piIntr,       // Interrupt wanted
   input  cpuPkg::piLevel  piReqLevel,   // Level to take
   input  logic            busDone,      // Bus cycle finished
   input  cpuPkg::word     rdData,       // Read data
   output logic            busStart,     // Start bus cycle
   output busPkg::busAddr  busReq,
   output logic            aluLoad,
   output cpuPkg::opCode   aluOp,
   output logic            atBoundary,   // Instruction boundary
   output logic            haltInstr,
   output logic            piTake,       // Level enters service
   output logic            piDismiss     // Level leaves service
);

   cpuPkg::seqState state;
   cpuPkg::seqState retState;            // State after the bus cycle
   cpuPkg::addr     pc;
   cpuPkg::word     ir;                  // Instruction register
   cpuPkg::addr     opAddr;
   logic            opRead;              // Op needs a memory operand

   assign aluOp  = cpuPkg::opCode'(ir[`WORD_BITS-1 -: 4]);
   assign opAddr = ir[`ADDR_BITS-1:0];   // Address field
   assign opRead = aluOp inside {cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opAnd,
                                 cpuPkg::opOr, cpuPkg::opXor, cpuPkg::opLoad};

   // Single cycle strobes
   assign atBoundary = (state == cpuPkg::stBoundary);
   assign piTake     = (state == cpuPkg::stIntr);
   assign aluLoad    = (state == cpuPkg::stOperand);   // rdData still held
   assign haltInstr  = (state == cpuPkg::stExec) && (aluOp == cpuPkg::opHalt);
   assign piDismiss  = (state == cpuPkg::stExec) && (aluOp == cpuPkg::opDismiss);

   //////////////////////////////
   // Bus cycle launch
   //////////////////////////////

   always_comb begin
      busStart = 1'b0;
      busReq   = '0;
      case (state)
         cpuPkg::stFetch: begin
            if (cpuRun && !piIntr) begin
               busStart       = 1'b1;    // Instruction fetch
               busReq.read    = 1'b1;
               busReq.address = pc;
            end
         end
         cpuPkg::stIntr: begin
            busStart       = 1'b1;       // Vector write
            busReq.write   = 1'b1;
            busReq.address = `INTR_BASE + cpuPkg::addr'(piReqLevel);
         end
         cpuPkg::stExec: begin
            busStart       = opRead;     // Operand read
            busReq.read    = opRead;
            busReq.address = opRead ? opAddr : '0;
         end
         cpuPkg::stStore: begin
            busStart       = 1'b1;
            busReq.write   = 1'b1;
            busReq.address = opAddr;
         end
         default: begin
         end
      endcase
   end

   //////////////////////////////
   // Control FSM
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= cpuPkg::stIdle;
         retState <= cpuPkg::stBoundary;
         pc       <= `START_ADDR;
      end else begin
         case (state)
            cpuPkg::stIdle:     if (cpuRun) state <= cpuPkg::stBoundary;
            cpuPkg::stBoundary: state <= cpuPkg::stFetch;   // Console acts here
            cpuPkg::stFetch: begin
               if (!cpuRun) begin
                  state <= cpuPkg::stIdle;                  // Halt took effect
               end else if (piIntr) begin
                  state <= cpuPkg::stIntr;
               end else begin
                  state    <= cpuPkg::stWait;
                  retState <= cpuPkg::stExec;
               end
            end
            cpuPkg::stIntr: begin
               state    <= cpuPkg::stWait;
               retState <= cpuPkg::stBoundary;              // PC unchanged
            end
            cpuPkg::stExec: begin
               pc <= pc + 1'b1;                             // Wraps at 18 bits
               if (opRead) begin
                  state    <= cpuPkg::stWait;
                  retState <= cpuPkg::stOperand;
               end else if (aluOp == cpuPkg::opStore) begin
                  state <= cpuPkg::stStore;
               end else begin
                  state <= cpuPkg::stBoundary;              // Ends on its fetch
               end
            end
            cpuPkg::stOperand:  state <= cpuPkg::stBoundary;
            cpuPkg::stStore: begin
               state    <= cpuPkg::stWait;
               retState <= cpuPkg::stBoundary;
            end
            cpuPkg::stWait:     if (busDone) state <= retState;
         endcase
      end
   end

   // IR loads as the fetch completes
   always_ff @(posedge clk) begin
      if (state == cpuPkg::stWait && busDone && retState == cpuPkg::stExec) begin
         ir <= rdData;
      end
   end

endmodule

// ==== hdl/alu.sv ====
/*
 * Arithmetic logic unit
 * Holds the accumulator and applies the memory operand to it
 */
`timescale 1ns/1ps

module alu (
   input  logic           clk,
   input  logic           reset,
   input  logic           aluLoad,    // Update strobe
   input  cpuPkg::opCode  aluOp,      // Operation, straight from IR
   input  cpuPkg::word    operand,    // Memory operand
   output cpuPkg::word    acc         // Accumulator
);

   //////////////////////////////
   // Accumulator
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         acc <= '0;
      end else if (aluLoad) begin
         case (aluOp)
            // Arithmetic wraps at 36 bits
            cpuPkg::opAdd: begin
               acc <= acc + operand;
            end
            cpuPkg::opSub: begin
               acc <= acc - operand;
            end
            // Bitwise ops
            cpuPkg::opAnd: begin
               acc <= acc & operand;
            end
            cpuPkg::opOr: begin
               acc <= acc | operand;
            end
            cpuPkg::opXor: begin
               acc <= acc ^ operand;
            end
            cpuPkg::opLoad: begin
               acc <= operand;          // Straight copy
            end
            default: begin
               acc <= acc;              // Store, halt, no-op
            end
         endcase
      end
   end

endmodule

// ==== hdl/busPkg.sv ====
/*
 * Bus types
 * Address and cycle flags sent with each bus request
 */

package busPkg;

   //////////////////////////////
   // Request address and flags
   //////////////////////////////

   // 20 bits, flags on top
   typedef struct packed {
      logic        read;      // Read cycle
      logic        write;     // Write cycle
      cpuPkg::addr address;   // Word address
   } busAddr;

   // Only one of read and write is ever set
   // All zero means no cycle

endpackage

// ==== hdl/cpuPkg.sv ====
/*
 * Processor types
 * Data words, addresses, opcodes, sequencer states and interrupt levels
 */
`include "cpu_consts.svh"

package cpuPkg;

   typedef logic [`WORD_BITS-1:0] word;   // Data word
   typedef logic [`ADDR_BITS-1:0] addr;   // Memory address

   // Interrupt level, 1 highest, 7 lowest
   typedef logic [2:0] piLevel;           // 0 means none

   //////////////////////////////
   // Opcode in bits 35..32
   //////////////////////////////

   typedef enum logic [3:0] {
      opAdd     = 4'h1,    // AC + mem
      opSub     = 4'h2,    // AC - mem
      opAnd     = 4'h3,
      opOr      = 4'h4,
      opXor     = 4'h5,
      opLoad    = 4'h6,    // AC = mem
      opStore   = 4'h7,    // mem = AC
      opDismiss = 4'h8,    // End of interrupt service
      opHalt    = 4'h9     // Unlisted codes do nothing
   } opCode;

   // Instruction control states
   typedef enum logic [2:0] {
      stIdle,              // Halted
      stBoundary,          // Between instructions
      stIntr,              // Vector write
      stFetch,             // Interrupt or fetch decision
      stExec,              // Decode
      stOperand,           // ALU load from read data
      stStore,             // Accumulator write
      stWait               // Bus cycle in flight
   } seqState;

endpackage

// ==== hdl/cpu_consts.svh ====
/*
 * Processor constants
 * Word and address widths, interrupt vectors, bus timeout, start address
 */
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Data word, PDP-10 style
`define WORD_BITS   36
// Physical address
`define ADDR_BITS   18

// First interrupt vector, level n lands at base plus n
`define INTR_BASE   18'o000040

// Cycles a request may wait for acknowledge
`define NXM_TIMEOUT 16
`define NXM_BITS    5

// PC after reset
`define START_ADDR  18'o000000
`endif
